// ==== Bender.yml ====
package:
  name: pong

sources:
  - logic/pong_geom_pkg.sv
  - logic/pong_play_pkg.sv
  - logic/paddle_bank.sv
  - logic/paddle_hit_detect.sv
  - logic/ball_motion.sv
  - logic/game_fsm.sv
  - logic/pong_top.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/pong_tb.sv

// ==== logic/ball_motion.sv ====
module ball_motion #(
  parameter int nudge = 5
) (
  input  logic                       ball_clk,
  input  logic                       reset,
  input  pong_play_pkg::game_state_t state,
  input  logic                       serve,
  input  pong_play_pkg::dir_t        serve_dir,
  input  pong_play_pkg::hit_t        hit,
  output pong_geom_pkg::point_t      ball,
  output pong_play_pkg::dir_t        ball_dir
);

  localparam pong_geom_pkg::coord_t nudge_c = pong_geom_pkg::coord_t'(nudge);
  localparam pong_geom_pkg::point_t centre =
    '{x: pong_geom_pkg::centre_x, y: pong_geom_pkg::centre_y};

  pong_geom_pkg::point_t ball_nxt;
  pong_play_pkg::dir_t   dir_nxt;

  always_comb begin
    ball_nxt = ball;
    dir_nxt  = ball_dir;
    // Step one pixel along the heading
    case (ball_dir)
      pong_play_pkg::dir_up_right:   ball_nxt = '{x: ball.x + 12'sd1, y: ball.y - 12'sd1};
      pong_play_pkg::dir_up_left:    ball_nxt = '{x: ball.x - 12'sd1, y: ball.y - 12'sd1};
      pong_play_pkg::dir_down_left:  ball_nxt = '{x: ball.x - 12'sd1, y: ball.y + 12'sd1};
      pong_play_pkg::dir_down_right: ball_nxt = '{x: ball.x + 12'sd1, y: ball.y + 12'sd1};
      pong_play_pkg::dir_right:      ball_nxt.x = ball.x + 12'sd1;
      pong_play_pkg::dir_left:       ball_nxt.x = ball.x - 12'sd1;
      default: ; // Unused codes park the ball
    endcase

    // Walls, each rule looks at the current heading, later rules win
    if (ball.y == pong_geom_pkg::wall_top) begin
      if (ball_dir == pong_play_pkg::dir_up_right) dir_nxt = pong_play_pkg::dir_down_right;
      else if (ball_dir == pong_play_pkg::dir_up_left) dir_nxt = pong_play_pkg::dir_down_left;
    end
    if (ball.y == pong_geom_pkg::wall_bottom) begin
      if (ball_dir == pong_play_pkg::dir_down_left) dir_nxt = pong_play_pkg::dir_up_left;
      else if (ball_dir == pong_play_pkg::dir_down_right) dir_nxt = pong_play_pkg::dir_up_right;
    end
    if (ball.x == pong_geom_pkg::wall_left) begin
      if (ball_dir == pong_play_pkg::dir_up_left) dir_nxt = pong_play_pkg::dir_up_right;
      else if (ball_dir == pong_play_pkg::dir_down_left) dir_nxt = pong_play_pkg::dir_down_right;
      else if (ball_dir == pong_play_pkg::dir_left) dir_nxt = pong_play_pkg::dir_right;
    end
    if (ball.x == pong_geom_pkg::wall_right) begin
      if (ball_dir == pong_play_pkg::dir_up_right) dir_nxt = pong_play_pkg::dir_up_left;
      else if (ball_dir == pong_play_pkg::dir_down_right) dir_nxt = pong_play_pkg::dir_down_left;
      else if (ball_dir == pong_play_pkg::dir_right) dir_nxt = pong_play_pkg::dir_left;
    end

    // Paddle deflection overrides walls, y keeps the step
    if (hit.valid) begin
      if (hit.back) begin
        ball_nxt.x = ball.x + nudge_c; // Push clear of the paddle
        case (hit.zone)
          pong_play_pkg::zone_upper: dir_nxt = pong_play_pkg::dir_up_right;
          pong_play_pkg::zone_lower: dir_nxt = pong_play_pkg::dir_down_left;
          default:                   dir_nxt = pong_play_pkg::dir_right;
        endcase
      end else begin
        ball_nxt.x = ball.x - nudge_c;
        case (hit.zone)
          pong_play_pkg::zone_upper: dir_nxt = pong_play_pkg::dir_up_left;
          pong_play_pkg::zone_lower: dir_nxt = pong_play_pkg::dir_down_right;
          default:                   dir_nxt = pong_play_pkg::dir_left;
        endcase
      end
    end
  end

  always_ff @(posedge ball_clk or negedge reset) begin
    if (!reset) begin
      ball     <= centre;
      ball_dir <= pong_play_pkg::dir_up_right;
    end else if (serve) begin // Rally over, back to the centre
      ball     <= centre;
      ball_dir <= serve_dir;
    end else if (state == pong_play_pkg::st_play) begin
      ball     <= ball_nxt;
      ball_dir <= dir_nxt;
    end
  end

endmodule

// ==== logic/game_fsm.sv ====
module game_fsm (
  input  logic                       ball_clk,
  input  logic                       reset,
  input  logic                       start_game, // Active low
  input  pong_geom_pkg::point_t      ball,
  output pong_play_pkg::game_state_t state,
  output logic                       serve,      // One cycle, end of rally
  output pong_play_pkg::dir_t        serve_dir
);

  pong_play_pkg::dir_t serve_ptr; // Heading handed out at the next goal
  logic                in_mouth;
  logic                goal;

  // Inside the mouth band and past a goal line
  assign in_mouth = (ball.y > pong_geom_pkg::goal_y_lo) &&
                    (ball.y < pong_geom_pkg::goal_y_hi) &&
                    ((ball.x < pong_geom_pkg::goal_x_lo) ||
                     (ball.x > pong_geom_pkg::goal_x_hi));

  assign goal = (state == pong_play_pkg::st_play) && in_mouth;

  always_ff @(posedge ball_clk or negedge reset) begin
    if (!reset) begin
      state     <= pong_play_pkg::st_idle;
      serve     <= 1'b0;
      serve_ptr <= pong_play_pkg::dir_up_left; // First serve
      serve_dir <= pong_play_pkg::dir_up_right;
    end else begin
      serve <= goal;
      case (state)
        pong_play_pkg::st_idle: if (!start_game) state <= pong_play_pkg::st_play;
        default:                if (goal) state <= pong_play_pkg::st_idle;
      endcase
      if (goal) begin
        serve_dir <= serve_ptr; // Old pointer goes out with the pulse
        // Rotate through all six headings
        if (serve_ptr == pong_play_pkg::dir_left) begin
          serve_ptr <= pong_play_pkg::dir_up_right;
        end else begin
          serve_ptr <= pong_play_pkg::dir_t'(serve_ptr + 3'd1);
        end
      end
    end
  end

endmodule

// ==== logic/paddle_bank.sv ====
module paddle_bank (
  input  logic                    ball_clk,
  input  logic                    reset,
  input  logic [3:0]              direction_switch,
  output pong_geom_pkg::paddles_t paddles
);

  logic [1:0] go_down;  // Per team, only its down bit set
  logic [1:0] go_up;    // Per team, only its up bit set
  logic [1:0] at_ceil;  // Some paddle of the team on the ceiling
  logic [1:0] at_floor; // Some paddle of the team on row 0

  // Team t owns paddles t, t+2 and t+4
  for (genvar t = 0; t < 2; t++) begin : g_team
    // Both bits set cancels out and the team holds
    assign go_down[t] = direction_switch[2*t] & ~direction_switch[2*t+1];
    assign go_up[t]   = direction_switch[2*t+1] & ~direction_switch[2*t];

    assign at_ceil[t] = (paddles[t].y == pong_geom_pkg::paddle_y_max) ||
                        (paddles[t+2].y == pong_geom_pkg::paddle_y_max) ||
                        (paddles[t+4].y == pong_geom_pkg::paddle_y_max);

    assign at_floor[t] = (paddles[t].y == 12'sd0) ||
                         (paddles[t+2].y == 12'sd0) ||
                         (paddles[t+4].y == 12'sd0);
  end

  always_ff @(posedge ball_clk or negedge reset) begin
    if (!reset) begin
      paddles <= pong_geom_pkg::paddle_home;
    end else begin
      // Only y moves, x is fixed from reset
      for (int i = 0; i < 6; i++) begin
        if (go_down[i % 2]) begin
          // Whole team wraps together on one shared decision
          if (at_ceil[i % 2]) begin
            paddles[i].y <= 12'sd0;
          end else begin
            paddles[i].y <= paddles[i].y + 12'sd1;
          end
        end else if (go_up[i % 2]) begin
          if (at_floor[i % 2]) begin
            paddles[i].y <= pong_geom_pkg::paddle_y_max; // Wrap to the bottom
          end else begin
            paddles[i].y <= paddles[i].y - 12'sd1;
          end
        end
      end
    end
  end

endmodule

// ==== logic/paddle_hit_detect.sv ====
module paddle_hit_detect #(
  parameter int paddle_w  = 15,
  parameter int paddle_h  = 60,
  parameter int ball_size = 50
) (
  input  pong_geom_pkg::paddles_t paddles,
  input  pong_geom_pkg::point_t   ball,
  output pong_play_pkg::hit_t     hit
);

  localparam int third = paddle_h / 3; // Zone split, rounded down

  logic [5:0]           front; // Ball left of the paddle and touching
  logic [5:0]           back;  // Ball right of the paddle and touching
  pong_play_pkg::zone_t zone [6];

  for (genvar i = 0; i < 6; i++) begin : g_paddle
    logic               span_y; // Vertical overlap, same test for both sides
    logic signed [12:0] d;      // Impact offset from the paddle y

    assign span_y = (ball.y + ball_size > paddles[i].y - paddle_h) &&
                    (ball.y - ball_size < paddles[i].y + paddle_h);

    assign front[i] = span_y &&
                      (ball.x + ball_size > paddles[i].x - paddle_w) &&
                      (ball.x < paddles[i].x);

    // Mirror of the front test in x
    assign back[i] = span_y &&
                     (ball.x - ball_size < paddles[i].x + paddle_w) &&
                     (ball.x > paddles[i].x);

    assign d = ball.y - paddles[i].y;

    // d of exactly 0 falls through to centre
    assign zone[i] = (d > 0 && d < third)      ? pong_play_pkg::zone_upper :
                     (d < 0 && d > -third)     ? pong_play_pkg::zone_lower :
                                                 pong_play_pkg::zone_centre;
  end

  // Priority pick, lowest paddle index wins
  always_comb begin
    hit = '{valid: 1'b0, back: 1'b0, zone: pong_play_pkg::zone_centre};
    for (int i = 5; i >= 0; i--) begin // Walk down so index 0 lands last
      if (front[i] || back[i]) begin
        hit.valid = 1'b1;
        hit.back  = back[i]; // Front and back never both set for one paddle
        hit.zone  = zone[i];
      end
    end
  end

endmodule

// ==== logic/pong_geom_pkg.sv ====
package pong_geom_pkg;

  // Signed, so a nudge past an edge still compares correctly
  typedef logic signed [11:0] coord_t;

  localparam coord_t field_w      = 12'sd640;
  localparam coord_t field_h      = 12'sd480;
  localparam coord_t paddle_y_max = 12'sd555; // Paddle wrap ceiling

  // Bounce lines
  localparam coord_t wall_left   = 12'sd20;
  localparam coord_t wall_right  = field_w - 12'sd20;
  localparam coord_t wall_top    = 12'sd0;
  localparam coord_t wall_bottom = field_h;

  localparam coord_t goal_y_lo = 12'sd140; // Mouth band, both ends exclusive
  localparam coord_t goal_y_hi = 12'sd340;
  localparam coord_t goal_x_lo = 12'sd21;  // Goal when x is below this
  localparam coord_t goal_x_hi = 12'sd619; // ... or above this

  localparam coord_t centre_x = field_w / 12'sd2; // Serve point
  localparam coord_t centre_y = field_h / 12'sd2;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } point_t;

  // Even index is team A, odd index is team B
  typedef point_t [5:0] paddles_t;

  localparam paddles_t paddle_home = {
    point_t'{x: 12'sd590, y: 12'sd240}, point_t'{x: 12'sd50, y: 12'sd240},
    point_t'{x: 12'sd490, y: 12'sd360}, point_t'{x: 12'sd150, y: 12'sd360},
    point_t'{x: 12'sd490, y: 12'sd120}, point_t'{x: 12'sd150, y: 12'sd120}
  };

endpackage

// ==== logic/pong_play_pkg.sv ====
package pong_play_pkg;

  // Ball heading, y grows downwards
  typedef enum logic [2:0] {
    dir_up_right   = 3'd0,
    dir_up_left    = 3'd1,
    dir_down_left  = 3'd2,
    dir_down_right = 3'd3,
    dir_right      = 3'd4, // Flat, x only
    dir_left       = 3'd5
  } dir_t;

  typedef enum logic {
    st_idle, // Ball parked, waiting for start_game
    st_play
  } game_state_t;

  // Where on the paddle the ball struck
  typedef enum logic [1:0] {
    zone_upper,
    zone_centre,
    zone_lower
  } zone_t;

  typedef struct packed {
    logic  valid; // Ball overlaps some paddle
    logic  back;  // Ball is right of the paddle x
    zone_t zone;
  } hit_t;

endpackage

// ==== logic/pong_top.sv ====
module pong_top #(
  parameter int paddle_w  = 15, // Paddle half extents used by the overlap test
  parameter int paddle_h  = 60,
  parameter int ball_size = 50,
  parameter int nudge     = 5   // Push away from a paddle on a hit
) (
  input  logic                       ball_clk,
  input  logic                       reset,
  input  logic [3:0]                 direction_switch,
  input  logic                       start_game,
  output pong_geom_pkg::paddles_t    paddles,
  output pong_geom_pkg::point_t      ball,
  output pong_play_pkg::dir_t        ball_dir,
  output pong_play_pkg::game_state_t state
);

  pong_play_pkg::hit_t hit;       // Combinational, from the current registers
  logic                serve;
  pong_play_pkg::dir_t serve_dir;

  paddle_bank u_paddle_bank (
    .ball_clk         (ball_clk),
    .reset            (reset),
    .direction_switch (direction_switch),
    .paddles          (paddles)
  );

  paddle_hit_detect #(
    .paddle_w  (paddle_w),
    .paddle_h  (paddle_h),
    .ball_size (ball_size)
  ) u_paddle_hit_detect (
    .paddles (paddles),
    .ball    (ball),
    .hit     (hit)
  );

  ball_motion #(.nudge(nudge)) u_ball_motion (
    .ball_clk  (ball_clk),
    .reset     (reset),
    .state     (state),
    .serve     (serve),
    .serve_dir (serve_dir),
    .hit       (hit),
    .ball      (ball),
    .ball_dir  (ball_dir)
  );

  game_fsm u_game_fsm (
    .ball_clk   (ball_clk),
    .reset      (reset),
    .start_game (start_game),
    .ball       (ball),
    .state      (state),
    .serve      (serve),
    .serve_dir  (serve_dir)
  );

endmodule

// ==== pong.f ====
logic/pong_geom_pkg.sv
logic/pong_play_pkg.sv
logic/paddle_bank.sv
logic/paddle_hit_detect.sv
logic/ball_motion.sv
logic/game_fsm.sv
logic/pong_top.sv
tb/tb_clock.sv
tb/pong_tb.sv

// ==== tb/pong_tb.sv ====
module pong_tb;

  localparam int pw = 15; // Paddle half width
  localparam int ph = 60; // Paddle half height
  localparam int bs = 50; // Ball reach
  localparam int nudge = 5;
  localparam int y_max = 555;
  localparam int start_limit = 500;   // Cycles allowed for play to begin
  localparam int goal_limit = 200000; // Cycles allowed for one rally
  localparam pong_geom_pkg::point_t centre = '{x: 12'sd320, y: 12'sd240};

  logic                       ball_clk;
  logic                       reset;
  logic [3:0]                 direction_switch;
  logic                       start_game;
  pong_geom_pkg::paddles_t    paddles;
  pong_geom_pkg::point_t      ball;
  pong_play_pkg::dir_t        ball_dir;
  pong_play_pkg::game_state_t state;

  // Reference model state, one edge ahead of the compare
  pong_geom_pkg::paddles_t    m_pad;
  pong_geom_pkg::point_t      m_ball;
  pong_play_pkg::dir_t        m_dir;
  pong_play_pkg::dir_t        m_ptr;  // Next serve heading
  pong_play_pkg::dir_t        m_sdir; // Heading loaded by the pending serve
  pong_play_pkg::game_state_t m_state;
  logic                       m_serve;
  logic [3:0]                 h_sw;    // Inputs the DUT samples at the next edge
  logic                       h_start;
  int                         goals;
  integer                     seed;
  pong_play_pkg::dir_t        rot [6] = '{pong_play_pkg::dir_up_left, pong_play_pkg::dir_down_left,
    pong_play_pkg::dir_down_right, pong_play_pkg::dir_right, pong_play_pkg::dir_left,
    pong_play_pkg::dir_up_right}; // Serve order after each goal

  tb_clock #(.period(40)) u_clock (.clk(ball_clk));

  pong_top #(.paddle_w(pw), .paddle_h(ph), .ball_size(bs), .nudge(nudge)) uut (
    .ball_clk(ball_clk), .reset(reset), .direction_switch(direction_switch),
    .start_game(start_game), .paddles(paddles), .ball(ball), .ball_dir(ball_dir),
    .state(state)
  );

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_point(input string name, input pong_geom_pkg::point_t exp, act);
    if (exp !== act) fail_stop($sformatf("CHECK FAILED t=%0t %s expected (%0d,%0d) got (%0d,%0d)",
      $time, name, exp.x, exp.y, act.x, act.y));
  endtask

  task automatic check_paddles(input string name, input pong_geom_pkg::paddles_t exp, act);
    if (exp !== act) fail_stop($sformatf("CHECK FAILED t=%0t %s expected %h got %h",
      $time, name, exp, act));
  endtask

  task automatic check_dir(input string name, input pong_play_pkg::dir_t exp, act);
    if (exp !== act) fail_stop($sformatf("CHECK FAILED t=%0t %s expected %0d got %0d",
      $time, name, exp, act));
  endtask

  task automatic check_state(input string name, input pong_play_pkg::game_state_t exp, act);
    if (exp !== act) fail_stop($sformatf("CHECK FAILED t=%0t %s expected %0d got %0d",
      $time, name, exp, act));
  endtask

  // Ball box against one paddle box, either side
  function automatic logic overlaps(input pong_geom_pkg::point_t p, b);
    int bx = b.x;
    int by = b.y;
    int px = p.x;
    int py = p.y;
    return (by + bs > py - ph) && (by - bs < py + ph) &&
      (((bx + bs > px - pw) && (bx < px)) || ((bx - bs < px + pw) && (bx > px)));
  endfunction

  function automatic pong_play_pkg::dir_t deflect(input pong_geom_pkg::point_t p, b);
    int  d = int'(b.y) - int'(p.y);
    logic rear = int'(b.x) > int'(p.x); // Ball struck the back face
    if (d > 0 && d < ph / 3) return rear ? pong_play_pkg::dir_up_right : pong_play_pkg::dir_up_left;
    if (d < 0 && d > -(ph / 3)) return rear ? pong_play_pkg::dir_down_left :
                                              pong_play_pkg::dir_down_right;
    return rear ? pong_play_pkg::dir_right : pong_play_pkg::dir_left; // Centre zone
  endfunction

  // Wall table, each rule reads the old heading and later rules win
  function automatic pong_play_pkg::dir_t wall_dir(input pong_geom_pkg::point_t b,
                                                   input pong_play_pkg::dir_t d);
    pong_play_pkg::dir_t n = d;
    if (b.y == 0 && d == pong_play_pkg::dir_up_right) n = pong_play_pkg::dir_down_right;
    if (b.y == 0 && d == pong_play_pkg::dir_up_left) n = pong_play_pkg::dir_down_left;
    if (b.y == 480 && d == pong_play_pkg::dir_down_left) n = pong_play_pkg::dir_up_left;
    if (b.y == 480 && d == pong_play_pkg::dir_down_right) n = pong_play_pkg::dir_up_right;
    if (b.x == 20 && d == pong_play_pkg::dir_up_left) n = pong_play_pkg::dir_up_right;
    if (b.x == 20 && d == pong_play_pkg::dir_down_left) n = pong_play_pkg::dir_down_right;
    if (b.x == 20 && d == pong_play_pkg::dir_left) n = pong_play_pkg::dir_right;
    if (b.x == 620 && d == pong_play_pkg::dir_up_right) n = pong_play_pkg::dir_up_left;
    if (b.x == 620 && d == pong_play_pkg::dir_down_right) n = pong_play_pkg::dir_down_left;
    if (b.x == 620 && d == pong_play_pkg::dir_right) n = pong_play_pkg::dir_left;
    return n;
  endfunction

  // Advance the model across one rising edge
  task automatic model_step();
    pong_geom_pkg::paddles_t pad = m_pad;
    pong_geom_pkg::point_t   nb = m_ball;
    pong_play_pkg::dir_t     nd = m_dir;
    int                      hi = -1;
    int                      bx = m_ball.x;
    int                      by = m_ball.y;
    int                      dx;
    int                      dy;
    logic                    down, up, top, bottom, goal;
    for (int t = 0; t < 2; t++) begin // Team A is t 0, team B is t 1
      down = h_sw[2*t] && !h_sw[2*t+1];
      up = h_sw[2*t+1] && !h_sw[2*t];
      top = (m_pad[t].y == y_max) || (m_pad[t+2].y == y_max) || (m_pad[t+4].y == y_max);
      bottom = (m_pad[t].y == 0) || (m_pad[t+2].y == 0) || (m_pad[t+4].y == 0);
      for (int k = t; k < 6; k += 2) begin
        if (down) pad[k].y = top ? 0 : m_pad[k].y + 1;
        if (up) pad[k].y = bottom ? y_max : m_pad[k].y - 1;
      end
    end
    for (int i = 5; i >= 0; i--) if (overlaps(m_pad[i], m_ball)) hi = i; // Lowest index wins
    dx = (m_dir inside {pong_play_pkg::dir_up_right, pong_play_pkg::dir_down_right,
                        pong_play_pkg::dir_right}) ? 1 : (m_dir inside {pong_play_pkg::dir_up_left,
                        pong_play_pkg::dir_down_left, pong_play_pkg::dir_left}) ? -1 : 0;
    dy = (m_dir inside {pong_play_pkg::dir_up_right, pong_play_pkg::dir_up_left}) ? -1 :
         (m_dir inside {pong_play_pkg::dir_down_left, pong_play_pkg::dir_down_right}) ? 1 : 0;
    if (m_serve) begin
      nb = centre;
      nd = m_sdir;
    end else if (m_state == pong_play_pkg::st_play) begin
      nb.x = bx + dx;
      nb.y = by + dy;
      nd = wall_dir(m_ball, m_dir);
      if (hi >= 0) begin
        nb.x = (bx > int'(m_pad[hi].x)) ? bx + nudge : bx - nudge; // Pushed off the face
        nd = deflect(m_pad[hi], m_ball);
      end
    end
    goal = (m_state == pong_play_pkg::st_play) && by > 140 && by < 340 && (bx < 21 || bx > 619);
    if (m_state == pong_play_pkg::st_idle && !h_start) m_state = pong_play_pkg::st_play;
    else if (goal) m_state = pong_play_pkg::st_idle;
    m_serve = goal;
    if (goal) begin
      m_sdir = m_ptr;
      m_ptr = pong_play_pkg::dir_t'((int'(m_ptr) + 1) % 6);
      goals++;
    end
    m_pad = pad;
    m_ball = nb;
    m_dir = nd;
  endtask

  task automatic run_cycle(input logic [3:0] sw, input logic st);
    @(posedge ball_clk);
    model_step();
    direction_switch <= sw; // Sampled at the next edge
    start_game <= st;
    h_sw = sw;
    h_start = st;
    @(negedge ball_clk); // Outputs settled
    check_paddles("paddles", m_pad, paddles);
    check_point("ball", m_ball, ball);
    check_dir("ball_dir", m_dir, ball_dir);
    check_state("state", m_state, state);
  endtask

  task automatic rand_cycle();
    logic [3:0] sw = $random(seed);
    logic       st = ($random(seed) & 7) != 0; // Low about one cycle in eight
    run_cycle(sw, st);
  endtask

  task automatic wait_play();
    int n = 0;
    while (state != pong_play_pkg::st_play) begin
      if (n == start_limit) fail_stop("play did not start within the cycle limit");
      rand_cycle();
      n++;
    end
  endtask

  task automatic wait_goal();
    int n = 0;
    while (state == pong_play_pkg::st_play) begin // Only a goal ends play
      if (n == goal_limit) fail_stop("no goal was scored within the cycle limit");
      rand_cycle();
      n++;
    end
  endtask

  initial begin
    seed = 32'he72d1487;
    reset = 1'b0;
    direction_switch = 4'd0;
    start_game = 1'b1;
    h_sw = 4'd0;
    h_start = 1'b1;
    m_pad[0] = '{12'sd150, 12'sd120}; // Home positions, team A on even index
    m_pad[1] = '{12'sd490, 12'sd120};
    m_pad[2] = '{12'sd150, 12'sd360};
    m_pad[3] = '{12'sd490, 12'sd360};
    m_pad[4] = '{12'sd50, 12'sd240};
    m_pad[5] = '{12'sd590, 12'sd240};
    m_ball = centre;
    m_dir = pong_play_pkg::dir_up_right;
    m_state = pong_play_pkg::st_idle;
    m_serve = 1'b0;
    m_ptr = pong_play_pkg::dir_up_left;
    m_sdir = pong_play_pkg::dir_up_right;
    goals = 0;
    repeat (16) @(posedge ball_clk);
    reset <= 1'b1;
    @(negedge ball_clk);
    check_paddles("paddles", m_pad, paddles); // Reset values
    check_point("ball", m_ball, ball);
    check_dir("ball_dir", m_dir, ball_dir);
    check_state("state", m_state, state);
    repeat (20) run_cycle(4'd0, 1'b1); // Idle, ball parked
    check_point("ball", centre, ball);
    // First flight from the centre runs into paddles at home
    // Then sweeps across paddles 0 and 4 while both overlap
    run_cycle(4'd0, 1'b0);
    repeat (400) run_cycle(4'd0, 1'b1);
    repeat (3000) rand_cycle();
    for (int k = 0; k < 6; k++) begin
      wait_play();
      wait_goal();
      rand_cycle(); // Serve edge
      check_point("ball", centre, ball);
      check_dir("ball_dir", rot[(goals - 1) % 6], ball_dir);
    end
    $display("%0d goals", goals);
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== tb/tb_clock.sv ====
module tb_clock #(
  parameter int period = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk; // Free running, first rise at period/2
  end

endmodule
